/* hv_item_gen_top.f */
verilog/axil_pkg.sv
verilog/item_mem_pkg.sv
verilog/reg_bus_if.sv
verilog/item_ctrl_if.sv
verilog/axil_slave_fsm.sv
verilog/hv_config_regs.sv
verilog/item_timer.sv
verilog/item_vector_gen.sv
verilog/hv_item_gen_top.sv
tests/tb_hv_item_gen.sv

/* tests/tb_hv_item_gen.sv */
`timescale 1ns/1ns

module tb_hv_item_gen;

    typedef enum int {op_write, op_read, op_gen} op_e;
    typedef enum int {wr_both, wr_addr_first, wr_data_first} wr_mode_e;
    typedef enum int {sel_awready, sel_wready, sel_arready, sel_bvalid, sel_rvalid} sig_sel_e;

    // one stimulus row, delays are extra cycles before BREADY / RREADY
    typedef struct packed {
        op_e         op;
        wr_mode_e    mode;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        int          bdly;
        int          rdly;
    } row_t;

    localparam int poll_limit = 50;
    localparam int gen_poll_limit = 100;

    logic        AXIS_ACLK;
    logic        S_AXI_ARESETN;
    logic [31:0] S_AXI_AWADDR;
    logic        S_AXI_AWVALID;
    logic        S_AXI_AWREADY;
    logic [31:0] S_AXI_WDATA;
    logic        S_AXI_WVALID;
    logic        S_AXI_WREADY;
    logic [1:0]  S_AXI_BRESP;
    logic        S_AXI_BVALID;
    logic        S_AXI_BREADY;
    logic [31:0] S_AXI_ARADDR;
    logic        S_AXI_ARVALID;
    logic        S_AXI_ARREADY;
    logic [31:0] S_AXI_RDATA;
    logic [1:0]  S_AXI_RRESP;
    logic        S_AXI_RVALID;
    logic        S_AXI_RREADY;

    integer seed = 32'h8cfdace1;
    row_t   table_q[$];

    hv_item_gen_top #(
        .ITEM_CYCLES (3)
    ) u_hv_item_gen_top (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY)
    );

    initial begin
        AXIS_ACLK = 1'b0;
        forever #5 AXIS_ACLK = ~AXIS_ACLK;
    end

    // ==============================
    // checks and reference model
    // ==============================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s never came", what);
        $display("Test FAILED");
        $fatal(1, "handshake timeout");
    endtask

    // xorshift32 applied n times from the seed
    function automatic logic [31:0] xorshift_ref(input int n);
        logic [31:0] x;
        x = 32'h2545F491;
        for (int i = 0; i < n; i++) begin
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
        end
        return x;
    endfunction

    // ==============================
    // bus tasks
    // ==============================
    function automatic logic sig_level(input sig_sel_e sel);
        case (sel)
            sel_awready: return S_AXI_AWREADY;
            sel_wready:  return S_AXI_WREADY;
            sel_arready: return S_AXI_ARREADY;
            sel_bvalid:  return S_AXI_BVALID;
            default:     return S_AXI_RVALID;
        endcase
    endfunction

    // sampled 1 ns after the falling edge, retried each cycle
    task automatic wait_level(input sig_sel_e sel, input string what);
        int waits;
        waits = 0;
        #1;
        while (!sig_level(sel)) begin
            waits++;
            if (waits > poll_limit) begin
                report_timeout(what);
            end
            @(negedge AXIS_ACLK);
            #1;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input wr_mode_e mode, input int bdly);
        @(negedge AXIS_ACLK);
        S_AXI_AWADDR = addr;
        S_AXI_WDATA  = data;
        case (mode)
            wr_both: begin
                S_AXI_AWVALID = 1'b1;
                S_AXI_WVALID  = 1'b1;
                wait_level(sel_awready, "AWREADY");
                wait_level(sel_wready, "WREADY");
                @(posedge AXIS_ACLK);
                @(negedge AXIS_ACLK);
                S_AXI_AWVALID = 1'b0;
                S_AXI_WVALID  = 1'b0;
            end
            wr_addr_first: begin
                S_AXI_AWVALID = 1'b1;
                wait_level(sel_awready, "AWREADY");
                @(posedge AXIS_ACLK);
                @(negedge AXIS_ACLK);
                S_AXI_AWVALID = 1'b0;
                S_AXI_WVALID  = 1'b1;
                wait_level(sel_wready, "WREADY");
                @(posedge AXIS_ACLK);
                @(negedge AXIS_ACLK);
                S_AXI_WVALID = 1'b0;
            end
            default: begin
                S_AXI_WVALID = 1'b1;
                wait_level(sel_wready, "WREADY");
                @(posedge AXIS_ACLK);
                @(negedge AXIS_ACLK);
                S_AXI_WVALID  = 1'b0;
                S_AXI_AWVALID = 1'b1;
                wait_level(sel_awready, "AWREADY");
                @(posedge AXIS_ACLK);
                @(negedge AXIS_ACLK);
                S_AXI_AWVALID = 1'b0;
            end
        endcase
        wait_level(sel_bvalid, "BVALID");
        check_value("S_AXI_BRESP", S_AXI_BRESP, 32'h0);
        // back-pressure, response must stay
        repeat (bdly) begin
            @(negedge AXIS_ACLK);
            #1;
            check_value("S_AXI_BVALID", S_AXI_BVALID, 32'h1);
        end
        @(negedge AXIS_ACLK);
        S_AXI_BREADY = 1'b1;
        @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        S_AXI_BREADY = 1'b0;
        #1;
        check_value("S_AXI_BVALID", S_AXI_BVALID, 32'h0);
    endtask

    task automatic read_reg(input logic [31:0] addr, input int rdly,
                            output logic [31:0] data);
        @(negedge AXIS_ACLK);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        wait_level(sel_arready, "ARREADY");
        @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        S_AXI_ARVALID = 1'b0;
        wait_level(sel_rvalid, "RVALID");
        data = S_AXI_RDATA;
        check_value("S_AXI_RRESP", S_AXI_RRESP, 32'h0);
        // data frozen while RREADY is low
        repeat (rdly) begin
            @(negedge AXIS_ACLK);
            #1;
            check_value("S_AXI_RVALID", S_AXI_RVALID, 32'h1);
            check_value("S_AXI_RDATA", S_AXI_RDATA, data);
        end
        @(negedge AXIS_ACLK);
        S_AXI_RREADY = 1'b1;
        @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        S_AXI_RREADY = 1'b0;
        #1;
        check_value("S_AXI_RVALID", S_AXI_RVALID, 32'h0);
    endtask

    // program count, start, poll gen bit, then check the captured vector
    task automatic run_items(input int count, input logic [31:0] exp, input int bdly,
                             input int rdly);
        logic [31:0] rd;
        int          polls;
        write_reg(32'h04, count, wr_both, bdly);
        write_reg(32'h00, 32'h1, wr_both, bdly);
        polls = 0;
        rd    = 32'h1;
        while (rd[0]) begin
            polls++;
            if (polls > gen_poll_limit) begin
                report_timeout("end of item run");
            end
            read_reg(32'h00, rdly, rd);
        end
        read_reg(32'h08, rdly, rd);
        check_value("reg_result", rd, exp);
    endtask

    // ==============================
    // stimulus table
    // ==============================
    task automatic add_row(input op_e op, input wr_mode_e mode, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
        row_t r;
        r.op   = op;
        r.mode = mode;
        r.addr = addr;
        r.data = data;
        r.exp  = exp;
        r.bdly = $unsigned($random(seed)) % 5;
        r.rdly = $unsigned($random(seed)) % 5;
        table_q.push_back(r);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        int          rnd_count;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        // item_count holds 16 bits only
        r1 = $random(seed) & 32'hffff;
        r2 = $random(seed) & 32'hffff;
        r3 = $random(seed) & 32'hffff;
        rnd_count = 3 + ($unsigned($random(seed)) % 38);

        // reset values
        add_row(op_read, wr_both, 32'h00, 32'h0, 32'h0);
        add_row(op_read, wr_both, 32'h04, 32'h0, 32'h0);
        add_row(op_read, wr_both, 32'h08, 32'h0, 32'h0);
        // readback, unmapped offsets and out-of-window addresses
        add_row(op_write, wr_both, 32'h04, 32'h1234, 32'h0);
        add_row(op_read, wr_both, 32'h04, 32'h0, 32'h1234);
        add_row(op_write, wr_both, 32'h0c, 32'hdead, 32'h0);
        add_row(op_read, wr_both, 32'h0c, 32'h0, 32'h0);
        add_row(op_write, wr_addr_first, 32'h404, 32'hffff, 32'h0);
        add_row(op_write, wr_data_first, 32'hc04, 32'h5555, 32'h0);
        // out-of-window read right after a nonzero read
        add_row(op_read, wr_both, 32'h04, 32'h0, 32'h1234);
        add_row(op_read, wr_both, 32'h404, 32'h0, 32'h0);
        // channel ordering
        add_row(op_write, wr_addr_first, 32'h04, r1, 32'h0);
        add_row(op_read, wr_both, 32'h04, 32'h0, r1);
        add_row(op_write, wr_data_first, 32'h04, r2, 32'h0);
        add_row(op_read, wr_both, 32'h04, 32'h0, r2);
        add_row(op_write, wr_both, 32'h04, r3, 32'h0);
        add_row(op_read, wr_both, 32'h04, 32'h0, r3);
        // item runs
        add_row(op_gen, wr_both, 32'h0, 32'd1, xorshift_ref(1));
        add_row(op_gen, wr_both, 32'h0, 32'd2, xorshift_ref(2));
        add_row(op_gen, wr_both, 32'h0, rnd_count, xorshift_ref(rnd_count));
        // abort of a long run keeps the old result
        add_row(op_write, wr_both, 32'h04, 32'd1000, 32'h0);
        add_row(op_write, wr_both, 32'h00, 32'h1, 32'h0);
        add_row(op_read, wr_both, 32'h00, 32'h0, 32'h1);
        add_row(op_write, wr_data_first, 32'h00, 32'h0, 32'h0);
        add_row(op_read, wr_both, 32'h00, 32'h0, 32'h0);
        add_row(op_read, wr_both, 32'h08, 32'h0, xorshift_ref(rnd_count));

        repeat (5) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;

        foreach (table_q[i]) begin
            case (table_q[i].op)
                op_write: begin
                    write_reg(table_q[i].addr, table_q[i].data, table_q[i].mode,
                              table_q[i].bdly);
                end
                op_read: begin
                    read_reg(table_q[i].addr, table_q[i].rdly, rd);
                    check_value($sformatf("S_AXI_RDATA at 0x%h", table_q[i].addr), rd,
                                table_q[i].exp);
                end
                default: begin
                    run_items(table_q[i].data, table_q[i].exp, table_q[i].bdly,
                              table_q[i].rdly);
                end
            endcase
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* verilog/axil_pkg.sv */
package axil_pkg;

    // ==============================
    // bus geometry
    // ==============================
    localparam int axil_addr_w = 32;
    localparam int axil_data_w = 32;

    // word index, address bits 11:2
    typedef logic [9:0] reg_index_t;

    // only OKAY is ever returned on B and R
    typedef enum logic [1:0] {
        resp_okay = 2'b00
    } axil_resp_e;

    // slave channel states
    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_addr_held  = 3'd1,
        st_data_held  = 3'd2,
        st_write_resp = 3'd3,
        st_read_fetch = 3'd4,
        st_read_resp  = 3'd5
    } axil_state_e;

    // register map by word index, byte offsets 0x00 / 0x04 / 0x08
    typedef enum logic [9:0] {
        reg_ctrl       = 10'd0,
        reg_item_count = 10'd1,
        reg_result     = 10'd2
    } reg_offset_e;

endpackage

/* verilog/axil_slave_fsm.sv */
`timescale 1ns/1ns

module axil_slave_fsm (
    input  logic                             AXIS_ACLK,
    input  logic                             S_AXI_ARESETN,
    input  logic [axil_pkg::axil_addr_w-1:0] S_AXI_AWADDR,
    input  logic                             S_AXI_AWVALID,
    output logic                             S_AXI_AWREADY,
    input  logic [axil_pkg::axil_data_w-1:0] S_AXI_WDATA,
    input  logic                             S_AXI_WVALID,
    output logic                             S_AXI_WREADY,
    output logic [1:0]                       S_AXI_BRESP,
    output logic                             S_AXI_BVALID,
    input  logic                             S_AXI_BREADY,
    input  logic [axil_pkg::axil_addr_w-1:0] S_AXI_ARADDR,
    input  logic                             S_AXI_ARVALID,
    output logic                             S_AXI_ARREADY,
    output logic [axil_pkg::axil_data_w-1:0] S_AXI_RDATA,
    output logic [1:0]                       S_AXI_RRESP,
    output logic                             S_AXI_RVALID,
    input  logic                             S_AXI_RREADY,
    reg_bus_if.slave                         bus
);
    import axil_pkg::*;

    axil_state_e            state;
    reg_index_t             addr_q;
    logic [axil_data_w-1:0] wdata_q;
    logic                   wr_first;
    logic                   rd_hit;
    logic                   in_window;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;

    // ==============================
    // channel handshakes
    // ==============================
    assign S_AXI_AWREADY = (state == st_idle) || (state == st_data_held);
    assign S_AXI_WREADY  = (state == st_idle) || (state == st_addr_held);
    // a pending write wins over a read in idle
    assign S_AXI_ARREADY = (state == st_idle) && !S_AXI_AWVALID && !S_AXI_WVALID;

    assign aw_hs = S_AXI_AWVALID && S_AXI_AWREADY;
    assign w_hs  = S_AXI_WVALID && S_AXI_WREADY;
    assign ar_hs = S_AXI_ARVALID && S_AXI_ARREADY;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= st_idle;
            wr_first <= 1'b0;
            rd_hit   <= 1'b0;
        end else begin
            wr_first <= 1'b0;
            case (state)
                st_idle: begin
                    if (aw_hs && w_hs) begin
                        state    <= st_write_resp;
                        wr_first <= 1'b1;
                    end else if (aw_hs) begin
                        state <= st_addr_held;
                    end else if (w_hs) begin
                        state <= st_data_held;
                    end else if (ar_hs) begin
                        state <= st_read_fetch;
                    end
                end
                // waiting for the missing half of the write
                st_addr_held: begin
                    if (w_hs) begin
                        state    <= st_write_resp;
                        wr_first <= 1'b1;
                    end
                end
                st_data_held: begin
                    if (aw_hs) begin
                        state    <= st_write_resp;
                        wr_first <= 1'b1;
                    end
                end
                st_write_resp: begin
                    if (S_AXI_BREADY) begin
                        state <= st_idle;
                    end
                end
                // register file samples its mux here
                st_read_fetch: begin
                    state  <= st_read_resp;
                    rd_hit <= in_window;
                end
                st_read_resp: begin
                    if (S_AXI_RREADY) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address and data holding
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_hs) begin
            addr_q <= S_AXI_AWADDR[11:2];
        end else if (ar_hs) begin
            addr_q <= S_AXI_ARADDR[11:2];
        end
        if (w_hs) begin
            wdata_q <= S_AXI_WDATA;
        end
    end

    // ==============================
    // register strobes
    // ==============================
    // address bits 11:10 must be zero
    assign in_window = (addr_q[9:8] == 2'b00);

    assign bus.index = addr_q;
    assign bus.wdata = wdata_q;
    // single strobe on entry to write_resp, not repeated under back-pressure
    assign bus.wr_en = wr_first && in_window;
    assign bus.rd_en = (state == st_read_fetch) && in_window;

    // responses
    assign S_AXI_BVALID = (state == st_write_resp);
    assign S_AXI_RVALID = (state == st_read_resp);
    assign S_AXI_BRESP  = resp_okay;
    assign S_AXI_RRESP  = resp_okay;
    // out-of-window reads return zero
    assign S_AXI_RDATA  = rd_hit ? bus.rdata : '0;

    a_one_resp: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(S_AXI_BVALID && S_AXI_RVALID));

    a_one_strobe: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(bus.rd_en && bus.wr_en));

endmodule

/* verilog/hv_config_regs.sv */
`timescale 1ns/1ns

module hv_config_regs (
    input  logic              AXIS_ACLK,
    input  logic              S_AXI_ARESETN,
    reg_bus_if.regs           bus,
    item_ctrl_if.regs         ctrl,
    input  item_mem_pkg::hv_t result
);
    import axil_pkg::*;
    import item_mem_pkg::*;

    reg_offset_e offset;
    logic        gen_q;
    item_count_t count_q;
    logic        ctrl_wr;
    logic        count_wr;

    // ==============================
    // decode
    // ==============================
    assign offset   = reg_offset_e'(bus.index);
    assign ctrl_wr  = bus.wr_en && (offset == reg_ctrl);
    assign count_wr = bus.wr_en && (offset == reg_item_count);

    // ==============================
    // control and count registers
    // ==============================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen_q   <= 1'b0;
            count_q <= '0;
        end else begin
            // bus write beats the self-clear
            if (ctrl_wr) begin
                gen_q <= bus.wdata[0];
            end else if (ctrl.item_done) begin
                gen_q <= 1'b0;
            end
            if (count_wr) begin
                count_q <= bus.wdata[item_count_w-1:0];
            end
        end
    end

    assign ctrl.gen        = gen_q;
    assign ctrl.item_count = count_q;

    // ==============================
    // read mux
    // ==============================
    // sampled on rd_en, held until the next read
    always_ff @(posedge AXIS_ACLK) begin
        if (bus.rd_en) begin
            case (offset)
                reg_ctrl: begin
                    bus.rdata <= {{(axil_data_w-1){1'b0}}, gen_q};
                end
                reg_item_count: begin
                    bus.rdata <= {{(axil_data_w-item_count_w){1'b0}}, count_q};
                end
                // last captured vector, read only
                reg_result: begin
                    bus.rdata <= result;
                end
                default: begin
                    bus.rdata <= '0;
                end
            endcase
        end
    end

endmodule

/* verilog/hv_item_gen_top.sv */
`timescale 1ns/1ns

module hv_item_gen_top #(
    parameter int ITEM_CYCLES = 1
) (
    input  logic                             AXIS_ACLK,
    input  logic                             S_AXI_ARESETN,
    // write address / data / response
    input  logic [axil_pkg::axil_addr_w-1:0] S_AXI_AWADDR,
    input  logic                             S_AXI_AWVALID,
    output logic                             S_AXI_AWREADY,
    input  logic [axil_pkg::axil_data_w-1:0] S_AXI_WDATA,
    input  logic                             S_AXI_WVALID,
    output logic                             S_AXI_WREADY,
    output logic [1:0]                       S_AXI_BRESP,
    output logic                             S_AXI_BVALID,
    input  logic                             S_AXI_BREADY,
    // read address / data
    input  logic [axil_pkg::axil_addr_w-1:0] S_AXI_ARADDR,
    input  logic                             S_AXI_ARVALID,
    output logic                             S_AXI_ARREADY,
    output logic [axil_pkg::axil_data_w-1:0] S_AXI_RDATA,
    output logic [1:0]                       S_AXI_RRESP,
    output logic                             S_AXI_RVALID,
    input  logic                             S_AXI_RREADY
);
    import item_mem_pkg::*;

    // captured vector, generator to register file
    hv_t result;

    reg_bus_if   reg_bus ();
    item_ctrl_if item_ctrl ();

    // ==============================
    // bus side
    // ==============================
    axil_slave_fsm u_axil_slave_fsm (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .bus           (reg_bus)
    );

    hv_config_regs u_hv_config_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .bus           (reg_bus),
        .ctrl          (item_ctrl),
        .result        (result)
    );

    // ==============================
    // generator side
    // ==============================
    item_timer #(
        .ITEM_CYCLES (ITEM_CYCLES)
    ) u_item_timer (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (item_ctrl)
    );

    item_vector_gen u_item_vector_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (item_ctrl),
        .result        (result)
    );

endmodule

/* verilog/item_ctrl_if.sv */
`timescale 1ns/1ns

interface item_ctrl_if;
    import item_mem_pkg::*;

    // run level, set by register write, cleared on done
    logic        gen;
    item_count_t item_count;
    // pulse per item
    logic        item_step;
    // pulse with the step of the last item
    logic        item_done;

    modport regs (output gen, item_count, input item_done);

    modport timer (input gen, item_count, output item_step, item_done);

    // generator only follows the pacing
    modport vector (input gen, item_step, item_done);

endinterface

/* verilog/item_mem_pkg.sv */
package item_mem_pkg;

    // ==============================
    // hypervector format
    // ==============================
    localparam int hv_dim = 32;
    typedef logic [hv_dim-1:0] hv_t;

    // item index and programmed item count
    localparam int item_count_w = 16;
    typedef logic [item_count_w-1:0] item_count_t;

    // ==============================
    // xorshift32 constants
    // ==============================
    localparam hv_t xs_seed = 32'h2545F491;

    localparam int xs_shift_a = 13;
    localparam int xs_shift_b = 17;
    localparam int xs_shift_c = 5;

endpackage

/* verilog/item_timer.sv */
`timescale 1ns/1ns

module item_timer #(
    parameter int ITEM_CYCLES = 1
) (
    input  logic       AXIS_ACLK,
    input  logic       S_AXI_ARESETN,
    item_ctrl_if.timer ctrl
);
    import item_mem_pkg::*;

    // at least one bit even for a single cycle per item
    localparam int cyc_w = (ITEM_CYCLES > 1) ? $clog2(ITEM_CYCLES) : 1;

    logic [cyc_w-1:0] cyc_cnt;
    item_count_t      item_idx;
    item_count_t      next_idx;
    logic             cyc_wrap;

    assign cyc_wrap = (cyc_cnt == cyc_w'(ITEM_CYCLES - 1));
    assign next_idx = item_idx + 1'b1;

    // ==============================
    // pacing and item index
    // ==============================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            cyc_cnt        <= '0;
            item_idx       <= '0;
            ctrl.item_step <= 1'b0;
            ctrl.item_done <= 1'b0;
        end else if (!ctrl.gen) begin
            // idle or aborted, restart from item 0
            cyc_cnt        <= '0;
            item_idx       <= '0;
            ctrl.item_step <= 1'b0;
            ctrl.item_done <= 1'b0;
        end else begin
            ctrl.item_step <= cyc_wrap;
            // done rides on the step of the last item
            ctrl.item_done <= cyc_wrap && (next_idx == ctrl.item_count);
            if (cyc_wrap) begin
                cyc_cnt  <= '0;
                item_idx <= next_idx;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // done must clear gen before the index runs past the count
    a_idx_bound: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        ctrl.gen |-> (item_idx <= ctrl.item_count));

endmodule

/* verilog/item_vector_gen.sv */
`timescale 1ns/1ns

module item_vector_gen (
    input  logic              AXIS_ACLK,
    input  logic              S_AXI_ARESETN,
    item_ctrl_if.vector       ctrl,
    output item_mem_pkg::hv_t result
);
    import item_mem_pkg::*;

    hv_t xs_state;
    hv_t xs_t1;
    hv_t xs_t2;
    hv_t xs_next;

    // ==============================
    // xorshift32 step
    // ==============================
    assign xs_t1   = xs_state ^ (xs_state << xs_shift_a);
    assign xs_t2   = xs_t1 ^ (xs_t1 >> xs_shift_b);
    assign xs_next = xs_t2 ^ (xs_t2 << xs_shift_c);

    // seed reload whenever no run is active
    always_ff @(posedge AXIS_ACLK) begin
        if (!ctrl.gen) begin
            xs_state <= xs_seed;
        end else if (ctrl.item_step) begin
            xs_state <= xs_next;
        end
    end

    // ==============================
    // final vector capture
    // ==============================
    // gen check drops a stale done after an abort
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            result <= '0;
        end else if (ctrl.gen && ctrl.item_done) begin
            // vector of the last item, not the one before
            result <= xs_next;
        end
    end

endmodule

/* verilog/reg_bus_if.sv */
`timescale 1ns/1ns

interface reg_bus_if;
    import axil_pkg::*;

    // one-cycle write strobe, index and wdata valid with it
    logic                   wr_en;
    // one-cycle read strobe
    logic                   rd_en;
    reg_index_t             index;
    logic [axil_data_w-1:0] wdata;
    // registered, valid from the cycle after rd_en
    logic [axil_data_w-1:0] rdata;

    // bus side
    modport slave (output wr_en, rd_en, index, wdata, input rdata);

    // register file side
    modport regs (input wr_en, rd_en, index, wdata, output rdata);

endinterface
